/* verilog.f */
+incdir+logic
logic/nocArbPkg.sv
logic/portLink.sv
logic/portIngress.sv
logic/grantTimer.sv
logic/grantSequencer.sv
logic/outputPortAllocator.sv
tests/outputPortAllocator_properties.sv
tests/outputPortAllocatorTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the output port allocator testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module outputPortAllocatorTb \
  -f verilog.f \
  --Mdir obj_dir \
  -o outputPortAllocatorSim

# keep the output even when the simulator exits with an error
simOut=$(./obj_dir/outputPortAllocatorSim +verilator+error+limit+100 2>&1) || true
echo "$simOut"

if grep -q "^Result: PASSED$" <<< "$simOut"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* tests/outputPortAllocatorTb.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module outputPortAllocatorTb;

  import nocArbPkg::*;

  localparam int testCycles = 10 + 15 + 40 + 15 + 40 + 400; // reset plus each test
  localparam int cycleLimit = testCycles + 100;

  logic                  clk;
  logic                  rst;
  logic [`NUM_PORTS-1:0] flitValid;
  flitKind_e             flitKind [`NUM_PORTS];
  logic [`LEN_WIDTH-1:0] pktLength [`NUM_PORTS];
  portSel_e              grantPort;
  logic [`NUM_PORTS-1:0] protocolError;

  int errorCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int cycleCount = 0;
  logic [31:0] lfsrState;

  // reference model state
  logic [`NUM_PORTS-1:0] refOpen;
  logic [`NUM_PORTS-1:0] refErr;
  int                    refLen [`NUM_PORTS];
  int                    refCount [`NUM_PORTS];
  portSel_e              refGrant;

  outputPortAllocator u_outputPortAllocator
  (
    .clk           (clk),
    .rst           (rst),
    .flitValid     (flitValid),
    .flitKind      (flitKind),
    .pktLength     (pktLength),
    .grantPort     (grantPort),
    .protocolError (protocolError)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    while (cycleCount <= cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: run went past %0d cycles", cycleLimit);
    $display("Result: FAILED");
    $finish;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic int randBits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++)
    begin
      v = (v << 1) | int'(lfsrState[0]);
      lfsrState = lfsrNext(lfsrState); // one step per bit
    end
    return v;
  endfunction

  task automatic checkGrant(input portSel_e got, input portSel_e exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s grantPort %s, expected %s", $time, what, got.name(),
               exp.name());
      errorCount++;
    end
  endtask

  task automatic checkErrors(input logic [`NUM_PORTS-1:0] got,
                             input logic [`NUM_PORTS-1:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s protocolError %b, expected %b", $time, what, got, exp);
      errorCount++;
    end
  endtask

  // one clock edge of the framing, timer and round-robin rules
  task automatic modelStep();
    logic [`NUM_PORTS-1:0] headAcc;
    logic [`NUM_PORTS-1:0] tailAcc;
    logic [`NUM_PORTS-1:0] viol;
    logic [`NUM_PORTS-1:0] quantumDone;
    portSel_e              nxt;
    int                    cur;
    headAcc = '0;
    tailAcc = '0;
    viol = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      quantumDone[p] = (refGrant == portSel_e'(p + 1)) && (refCount[p] == refLen[p]);
      if (flitValid[p])
      begin
        case (flitKind[p])
          flitNone:
          begin
          end
          flitHead:
          begin
            if (refOpen[p]) viol[p] = 1'b1;
            else headAcc[p] = 1'b1;
          end
          flitBody:
          begin
            if (!refOpen[p]) viol[p] = 1'b1;
          end
          flitTail:
          begin
            if (refOpen[p]) tailAcc[p] = 1'b1;
            else viol[p] = 1'b1;
          end
          default:
          begin
            viol[p] = 1'b1;
          end
        endcase
      end
    end
    nxt = portIdle;
    if (refGrant == portIdle)
    begin
      for (int p = `NUM_PORTS - 1; p >= 0; p--)
        if (refOpen[p]) nxt = portSel_e'(p + 1); // lowest index ends up chosen
    end
    else
    begin
      cur = int'(refGrant) - 1;
      if (refOpen[cur] && !quantumDone[cur])
        nxt = refGrant;
      else
        for (int off = `NUM_PORTS - 1; off >= 1; off--)
          if (refOpen[(cur + off) % `NUM_PORTS]) nxt = portSel_e'((cur + off) % `NUM_PORTS + 1);
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (refGrant == portSel_e'(p + 1)) refCount[p]++;
      else refCount[p] = 1;
      if (headAcc[p]) refLen[p] = int'(pktLength[p]);
    end
    refOpen = (refOpen | headAcc) & ~tailAcc;
    refErr = refErr | viol;
    refGrant = nxt;
  endtask

  task automatic resetModel();
    refOpen = '0;
    refErr = '0;
    refGrant = portIdle;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      refLen[p] = 0;
      refCount[p] = 1;
    end
  endtask

  // inputs set before this are taken at the next edge
  task automatic tick();
    @(posedge clk);
    modelStep();
    #1;
    checkGrant(grantPort, refGrant, "model");
    checkErrors(protocolError, refErr, "model");
    flitValid = '0;
  endtask

  task automatic sendFlit(input int port, input flitKind_e kind, input int len);
    flitValid[port] = 1'b1;
    flitKind[port] = kind;
    pktLength[port] = `LEN_WIDTH'(len);
  endtask

  task automatic waitGrant(input portSel_e want, input int maxCycles, input string what);
    int n;
    n = 0;
    while (grantPort !== want && n < maxCycles)
    begin
      tick();
      n++;
    end
    if (grantPort !== want)
    begin
      $display("%s: grant did not reach %s within %0d cycles", what, want.name(), maxCycles);
      errorCount++;
    end
  endtask

  task automatic testDone(input string name, input int startErr);
    testsRun++;
    if (errorCount == startErr)
      $display("test %s: ok", name);
    else
    begin
      testsFailed++;
      $display("test %s: %0d errors", name, errorCount - startErr);
    end
  endtask

  task automatic resetState();
    int startErr;
    startErr = errorCount;
    checkGrant(grantPort, portIdle, "after reset");
    checkErrors(protocolError, 5'b00000, "after reset");
    testDone("reset state", startErr);
  endtask

  task automatic loneEast();
    int       startErr;
    portSel_e want;
    startErr = errorCount;
    sendFlit(2, flitHead, 3);
    tick(); // head accepted here
    checkGrant(grantPort, portIdle, "east head edge");
    for (int n = 1; n <= 10; n++)
    begin
      tick();
      want = ((n - 1) % 4 < 3) ? portEast : portIdle; // 3 granted then 1 idle
      checkGrant(grantPort, want, "east quantum");
    end
    sendFlit(2, flitTail, 0);
    tick();
    tick();
    checkGrant(grantPort, portIdle, "east after tail");
    testDone("lone east packet", startErr);
  endtask

  task automatic contention();
    int startErr;
    int lens [`NUM_PORTS];
    startErr = errorCount;
    lens = '{2, 3, 1, 4, 2};
    for (int p = 0; p < `NUM_PORTS; p++)
      sendFlit(p, flitHead, lens[p]);
    tick();
    for (int p = 0; p < `NUM_PORTS; p++)
      for (int c = 0; c < lens[p]; c++)
      begin
        tick();
        checkGrant(grantPort, portSel_e'(p + 1), "rotation");
      end
    tick();
    checkGrant(grantPort, portLocal, "wrap to local");
    for (int p = 0; p < `NUM_PORTS; p++)
      sendFlit(p, flitTail, 0);
    tick();
    waitGrant(portIdle, 10, "contention close");
    testDone("contention", startErr);
  endtask

  task automatic earlyRelease();
    int startErr;
    startErr = errorCount;
    sendFlit(1, flitHead, 10);
    sendFlit(2, flitHead, 10);
    sendFlit(4, flitHead, 10);
    tick();
    tick();
    checkGrant(grantPort, portNorth, "first owner");
    tick();
    sendFlit(1, flitTail, 0); // quantum far from used up
    tick();
    tick();
    checkGrant(grantPort, portEast, "release north");
    sendFlit(2, flitTail, 0);
    tick();
    tick();
    checkGrant(grantPort, portSouth, "release east");
    sendFlit(4, flitTail, 0);
    tick();
    tick();
    checkGrant(grantPort, portIdle, "release south");
    testDone("early release", startErr);
  endtask

  task automatic framingErrors();
    int startErr;
    startErr = errorCount;
    sendFlit(0, flitBody, 0); // body with no open packet
    tick();
    checkErrors(protocolError, 5'b00001, "body on closed port");
    sendFlit(1, flitHead, 2);
    tick();
    tick();
    checkGrant(grantPort, portNorth, "north owner");
    sendFlit(1, flitHead, 7);
    tick();
    checkErrors(protocolError, 5'b00011, "second head");
    sendFlit(3, flitKind_e'(3'd6), 0);
    tick();
    checkErrors(protocolError, 5'b01011, "illegal code");
    for (int n = 0; n < 6; n++)
      tick();
    sendFlit(1, flitTail, 0);
    tick();
    waitGrant(portIdle, 10, "framing close");
    checkErrors(protocolError, 5'b01011, "errors sticky");
    testDone("framing errors", startErr);
  endtask

  task automatic randomTraffic();
    int startErr;
    int len;
    startErr = errorCount;
    for (int c = 0; c < 400; c++)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (randBits(2) == 3)
        begin
          len = randBits(4);
          if (len == 0) len = 1;
          sendFlit(p, flitKind_e'(randBits(2)), len);
        end
      end
      tick();
    end
    testDone("random traffic", startErr);
  endtask

  initial
  begin
    lfsrState = 32'hfd5d_3c75;
    rst = 1'b1;
    flitValid = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      flitKind[p] = flitNone;
      pktLength[p] = '0;
    end
    resetModel();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    resetState();
    loneEast();
    contention();
    earlyRelease();
    framingErrors();
    randomTraffic();
    if (u_outputPortAllocator.u_outputPortAllocatorProperties.failCount != 0)
    begin
      $display("%0d assertion failures were seen",
               u_outputPortAllocator.u_outputPortAllocatorProperties.failCount);
      errorCount++;
    end
    $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* tests/outputPortAllocator_properties.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module outputPortAllocatorProperties
(
  input logic                  clk,
  input logic                  rst,
  input nocArbPkg::portSel_e   grantPort,
  input logic [`NUM_PORTS-1:0] protocolError,
  input logic [`NUM_PORTS-1:0] req
);

  import nocArbPkg::*;

  int                    failCount = 0; // assertion failures so far
  logic [`NUM_PORTS-1:0] reqPrev;
  logic [2:0]            ownerIdx;

  always_ff @(posedge clk)
  begin
    if (rst)
      reqPrev <= '0;
    else
      reqPrev <= req;
  end

  assign ownerIdx = 3'(grantPort) - 3'd1; // only used when a port owns the grant

  legalGrant: assert property (@(posedge clk) grantPort <= portSouth)
    else begin failCount++; $error("grantPort holds an illegal code"); end

  stickyErrors: assert property (@(posedge clk)
    (!rst && !$past(rst)) |-> ((protocolError & $past(protocolError)) == $past(protocolError)))
    else begin failCount++; $error("a protocolError bit fell without reset"); end

  // a port only wins the grant if it requested in the cycle before
  grantNeedsReq: assert property (@(posedge clk) disable iff (rst)
    (grantPort != portIdle && grantPort != $past(grantPort)) |-> reqPrev[ownerIdx])
    else begin failCount++; $error("grant went to a port without a request"); end

endmodule

bind outputPortAllocator outputPortAllocatorProperties u_outputPortAllocatorProperties
(
  .clk           (clk),
  .rst           (rst),
  .grantPort     (grantPort),
  .protocolError (protocolError),
  .req           (u_portIngress.openPkt)
);

/* logic/outputPortAllocator.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module outputPortAllocator
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`NUM_PORTS-1:0]  flitValid,
  input  nocArbPkg::flitKind_e   flitKind [`NUM_PORTS],
  input  logic [`LEN_WIDTH-1:0]  pktLength [`NUM_PORTS],
  output nocArbPkg::portSel_e    grantPort,
  output logic [`NUM_PORTS-1:0]  protocolError
);

  // one link per input port with Local at index 0
  portLink links [`NUM_PORTS] ();

  portIngress u_portIngress
  (
    .clk           (clk),
    .rst           (rst),
    .flitValid     (flitValid),
    .flitKind      (flitKind),
    .pktLength     (pktLength),
    .links         (links),
    .protocolError (protocolError)
  );

  // grant quantum per port
  generate
    for (genvar i = 0; i < `NUM_PORTS; i++)
    begin : g_timer
      grantTimer u_grantTimer
      (
        .clk  (clk),
        .rst  (rst),
        .link (links[i])
      );
    end
  endgenerate

  grantSequencer u_grantSequencer
  (
    .clk       (clk),
    .rst       (rst),
    .links     (links),
    .grantPort (grantPort)
  );

endmodule

/* logic/grantSequencer.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module grantSequencer
(
  input  logic               clk,
  input  logic               rst,
  portLink.sequencer         links [`NUM_PORTS],
  output nocArbPkg::portSel_e grantPort
);

  import nocArbPkg::*;

  portSel_e              state;
  portSel_e              nextState;
  logic [`NUM_PORTS-1:0] reqVec;
  logic [`NUM_PORTS-1:0] timesUpVec;
  logic [`NUM_PORTS-1:0] others;
  int                    grantIdx;

  // first candidate from base onward with wraparound
  function automatic portSel_e pickFrom
  (
    input logic [`NUM_PORTS-1:0] cand,
    input int                    base
  );
    portSel_e pick;
    logic     found;
    int       idx;
    pick  = portIdle;
    found = 1'b0;
    for (int off = 0; off < `NUM_PORTS; off++)
    begin
      idx = (base + off) % `NUM_PORTS;
      if (!found && cand[idx])
      begin
        pick  = portSel_e'(idx + 1);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  generate
    for (genvar i = 0; i < `NUM_PORTS; i++)
    begin : g_port
      assign reqVec[i]     = links[i].req;
      assign timesUpVec[i] = links[i].timesUp;
      assign links[i].run  = (state == portSel_e'(i + 1)); // only the owner runs
    end
  endgenerate

  always_comb
  begin
    grantIdx  = int'(state) - 1;
    others    = reqVec & ~(`NUM_PORTS'(1) << grantIdx); // current owner excluded
    nextState = portIdle;
    case (state)
      portIdle:
      begin
        nextState = pickFrom(reqVec, 0); // lowest index wins
      end
      portLocal, portNorth, portEast, portWest, portSouth:
      begin
        if (reqVec[grantIdx] && !timesUpVec[grantIdx])
          nextState = state;
        else
          nextState = pickFrom(others, (grantIdx + 1) % `NUM_PORTS);
      end
      default:
      begin
        nextState = portIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= portIdle;
    else
      state <= nextState;
  end

  assign grantPort = state;

endmodule

/* logic/grantTimer.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module grantTimer
(
  input  logic    clk,
  input  logic    rst,
  portLink.timer  link
);

  logic [`LEN_WIDTH-1:0] storedLength;
  logic [`LEN_WIDTH-1:0] grantCount;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      storedLength <= '0;
      grantCount   <= `LEN_WIDTH'(1);
    end
    else
    begin
      if (link.loadLength)
        storedLength <= link.length; // head accepted on this port

      // first granted cycle counts as 1
      if (link.run)
        grantCount <= grantCount + 1'b1;
      else
        grantCount <= `LEN_WIDTH'(1);
    end
  end

  // quantum reached in the current granted cycle
  assign link.timesUp = link.run && (grantCount == storedLength);

endmodule

/* logic/portIngress.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

module portIngress
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`NUM_PORTS-1:0]  flitValid,
  input  nocArbPkg::flitKind_e   flitKind [`NUM_PORTS],
  input  logic [`LEN_WIDTH-1:0]  pktLength [`NUM_PORTS],
  portLink.ingress               links [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0]  protocolError
);

  import nocArbPkg::*;

  logic [`NUM_PORTS-1:0] openPkt;
  logic [`NUM_PORTS-1:0] headAccept;
  logic [`NUM_PORTS-1:0] tailAccept;
  logic [`NUM_PORTS-1:0] violation;

  // accept or reject every incoming flit
  always_comb
  begin
    headAccept = '0;
    tailAccept = '0;
    violation  = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (flitValid[p])
      begin
        case (flitKind[p])
          flitHead:
          begin
            if (openPkt[p])
              violation[p] = 1'b1; // second head inside a packet
            else
              headAccept[p] = 1'b1;
          end
          flitBody:
          begin
            violation[p] = !openPkt[p]; // body needs an open packet
          end
          flitTail:
          begin
            if (openPkt[p])
              tailAccept[p] = 1'b1;
            else
              violation[p] = 1'b1;
          end
          default:
          begin
            violation[p] = (flitKind[p] != flitNone); // illegal codes
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      openPkt       <= '0;
      protocolError <= '0;
    end
    else
    begin
      openPkt       <= (openPkt | headAccept) & ~tailAccept;
      protocolError <= protocolError | violation; // sticky until reset
    end
  end

  // per-port link outputs
  generate
    for (genvar i = 0; i < `NUM_PORTS; i++)
    begin : g_link
      assign links[i].req        = openPkt[i];
      assign links[i].loadLength = headAccept[i];
      assign links[i].length     = pktLength[i];
    end
  endgenerate

endmodule

/* logic/portLink.sv */
`timescale 1ns/1ps
`include "noc_settings.svh"

interface portLink;

  logic                  req;        // packet open on this port
  logic                  loadLength; // head accepted this cycle
  logic [`LEN_WIDTH-1:0] length;     // head length, valid with loadLength
  logic                  run;        // port holds the grant
  logic                  timesUp;    // quantum used up

  modport ingress
  (
    output req,
    output loadLength,
    output length
  );

  modport timer
  (
    input  loadLength,
    input  length,
    input  run,
    output timesUp
  );

  modport sequencer
  (
    input  req,
    input  timesUp,
    output run
  );

endinterface

/* logic/nocArbPkg.sv */
`include "noc_settings.svh"

package nocArbPkg;

  // kind of the flit presented with flitValid
  typedef enum logic [`FLIT_ID_WIDTH-1:0]
  {
    flitNone = 3'd0,
    flitHead = 3'd1, // opens a packet and carries the length
    flitBody = 3'd2,
    flitTail = 3'd3  // closes the packet
  } flitKind_e;

  // grant owner and sequencer state
  // port index i maps to value i+1
  typedef enum logic [2:0]
  {
    portIdle  = 3'd0,
    portLocal = 3'd1,
    portNorth = 3'd2,
    portEast  = 3'd3,
    portWest  = 3'd4,
    portSouth = 3'd5
  } portSel_e;

endpackage

/* logic/noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// five compass ports of one mesh router output
`define NUM_PORTS 5

// head flit length field
`define LEN_WIDTH 12

// flit kind code on each input
`define FLIT_ID_WIDTH 3

`endif
